// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing --assert -Wall
TOP = cameraBasisTb
FILELIST = verilog.f
OBJDIR = obj_dir
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Simulation completed successfully" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== source/basisSequencer.sv ====
// Job control for the camera basis: accepts a job, shares the normalizer and presents n, v, u
`timescale 1ns/100ps

module basisSequencer import cameraPkg::*; (
	input  logic iClk,
	input  logic arstN,
	input  logic inValid,
	output logic inReady,
	input  fixT  lookFromX, lookFromY, lookFromZ,
	input  fixT  lookToX, lookToY, lookToZ,
	input  fixT  upX, upY, upZ,
	output logic outValid,
	input  logic outReady,
	output logic degenerate,
	output logic normStart,
	output fixT  normX, normY, normZ,
	input  logic normDone,
	input  fixT  unitX, unitY, unitZ,
	input  logic zeroLength,
	output logic orthoStart,
	input  fixT  orthoX, orthoY, orthoZ,
	output logic crossStart,
	input  fixT  crossX, crossY, crossZ,
	output fixT  nX, nY, nZ,
	output fixT  vX, vY, vZ,
	output fixT  uX, uY, uZ
);

	logic [2:0] state;
	fixT upHoldX, upHoldY, upHoldZ;
	logic abortJob;

	assign inReady = (state == SEQ_IDLE);

	// Zero view direction or up parallel to n
	assign abortJob = normDone && zeroLength &&
		(state == SEQ_NORM_DIR || state == SEQ_NORM_V);

	always_ff @(posedge iClk or negedge arstN) begin
		if (!arstN) begin
			state <= SEQ_IDLE;
			outValid <= 1'b0;
			degenerate <= 1'b0;
			normStart <= 1'b0;
			orthoStart <= 1'b0;
			crossStart <= 1'b0;
		end else begin
			normStart <= 1'b0;
			orthoStart <= 1'b0;
			crossStart <= 1'b0;
			if (abortJob) begin
				nX <= '0;
				nY <= '0;
				nZ <= '0;
				vX <= '0;
				vY <= '0;
				vZ <= '0;
				uX <= '0;
				uY <= '0;
				uZ <= '0;
				degenerate <= 1'b1;
				outValid <= 1'b1;
				state <= SEQ_PRESENT;
			end else begin
				case (state)
					SEQ_IDLE: begin
						if (inValid) begin
							normX <= lookToX - lookFromX;
							normY <= lookToY - lookFromY;
							normZ <= lookToZ - lookFromZ;
							upHoldX <= upX;
							upHoldY <= upY;
							upHoldZ <= upZ;
							normStart <= 1'b1;
							state <= SEQ_NORM_DIR;
						end
					end
					SEQ_NORM_DIR: begin
						if (normDone) begin
							nX <= unitX;
							nY <= unitY;
							nZ <= unitZ;
							normX <= upHoldX;
							normY <= upHoldY;
							normZ <= upHoldZ;
							normStart <= 1'b1;
							state <= SEQ_NORM_UP;
						end
					end
					SEQ_NORM_UP: begin
						// Normalized up stays on the unit outputs for the orthogonalizer
						if (normDone) begin
							orthoStart <= 1'b1;
							state <= SEQ_ORTHO;
						end
					end
					SEQ_ORTHO: begin
						if (!orthoStart) begin
							normX <= orthoX;
							normY <= orthoY;
							normZ <= orthoZ;
							normStart <= 1'b1;
							state <= SEQ_NORM_V;
						end
					end
					SEQ_NORM_V: begin
						if (normDone) begin
							vX <= unitX;
							vY <= unitY;
							vZ <= unitZ;
							crossStart <= 1'b1;
							state <= SEQ_CROSS;
						end
					end
					SEQ_CROSS: begin
						// cross result is registered one cycle after crossStart
						if (!crossStart) begin
							uX <= crossX;
							uY <= crossY;
							uZ <= crossZ;
							outValid <= 1'b1;
							state <= SEQ_PRESENT;
						end
					end
					SEQ_PRESENT: begin
						if (outReady) begin
							outValid <= 1'b0;
							degenerate <= 1'b0;
							state <= SEQ_IDLE;
						end
					end
					default: state <= SEQ_IDLE;
				endcase
			end
		end
	end

endmodule

// ==== source/cameraBasis.sv ====
// Camera basis top level, connecting the job sequencer to the shared normalizer and its datapath
`timescale 1ns/100ps

module cameraBasis import cameraPkg::*; (
	input  logic iClk,
	input  logic arstN,
	input  logic inValid,
	output logic inReady,
	input  fixT  lookFromX, lookFromY, lookFromZ,
	input  fixT  lookToX, lookToY, lookToZ,
	input  fixT  upX, upY, upZ,
	output logic outValid,
	input  logic outReady,
	output fixT  nX, nY, nZ,
	output fixT  vX, vY, vZ,
	output fixT  uX, uY, uZ,
	output logic degenerate
);

	logic normStart, normDone, zeroLength;
	fixT normX, normY, normZ;
	fixT unitX, unitY, unitZ;
	logic orthoStart, crossStart;
	fixT orthoX, orthoY, orthoZ;
	fixT crossX, crossY, crossZ;

	basisSequencer sequencer (
		.iClk(iClk), .arstN(arstN),
		.inValid(inValid), .inReady(inReady),
		.lookFromX(lookFromX), .lookFromY(lookFromY), .lookFromZ(lookFromZ),
		.lookToX(lookToX), .lookToY(lookToY), .lookToZ(lookToZ),
		.upX(upX), .upY(upY), .upZ(upZ),
		.outValid(outValid), .outReady(outReady), .degenerate(degenerate),
		.normStart(normStart), .normX(normX), .normY(normY), .normZ(normZ),
		.normDone(normDone), .unitX(unitX), .unitY(unitY), .unitZ(unitZ),
		.zeroLength(zeroLength),
		.orthoStart(orthoStart), .orthoX(orthoX), .orthoY(orthoY), .orthoZ(orthoZ),
		.crossStart(crossStart), .crossX(crossX), .crossY(crossY), .crossZ(crossZ),
		.nX(nX), .nY(nY), .nZ(nZ),
		.vX(vX), .vY(vY), .vZ(vZ),
		.uX(uX), .uY(uY), .uZ(uZ)
	);

	// One normalizer serves the direction, up and true-up steps
	vectorNormalizer normalizer (
		.iClk(iClk), .arstN(arstN),
		.normStart(normStart), .normX(normX), .normY(normY), .normZ(normZ),
		.normDone(normDone), .unitX(unitX), .unitY(unitY), .unitZ(unitZ),
		.zeroLength(zeroLength)
	);

	upOrthogonalizer orthogonalizer (
		.iClk(iClk), .arstN(arstN), .orthoStart(orthoStart),
		.nX(nX), .nY(nY), .nZ(nZ),
		.upX(unitX), .upY(unitY), .upZ(unitZ),
		.orthoX(orthoX), .orthoY(orthoY), .orthoZ(orthoZ)
	);

	// u = n x v
	crossProduct crosser (
		.iClk(iClk), .arstN(arstN), .crossStart(crossStart),
		.aX(nX), .aY(nY), .aZ(nZ),
		.bX(vX), .bY(vY), .bZ(vZ),
		.crossX(crossX), .crossY(crossY), .crossZ(crossZ)
	);

endmodule

// ==== source/cameraPkg.sv ====
// Fixed-point type, arithmetic constants and state codes shared by the camera basis RTL and testbench
package cameraPkg;

	// Signed Q5.12 word used for every coordinate and vector component
	localparam int FIX_WIDTH = 18;
	localparam int FRAC_BITS = 12;

	typedef logic signed [FIX_WIDTH-1:0] fixT;

	localparam fixT FIX_ONE = fixT'(1 << FRAC_BITS);

	// Iteration counts of the serial normalizer
	localparam int SQRT_STEPS = 18;
	localparam int DIV_STEPS = 18;

	// Start to done of a nonzero normalization
	localparam int NORM_CYCLES = 2 + SQRT_STEPS + 3 * DIV_STEPS;

	// Normalizer states
	localparam logic [1:0] NORM_IDLE = 2'd0;
	localparam logic [1:0] NORM_SUM = 2'd1;
	localparam logic [1:0] NORM_SQRT = 2'd2;
	localparam logic [1:0] NORM_DIV = 2'd3;

	// Sequencer states, in job order
	localparam logic [2:0] SEQ_IDLE = 3'd0;
	localparam logic [2:0] SEQ_NORM_DIR = 3'd1;
	localparam logic [2:0] SEQ_NORM_UP = 3'd2;
	localparam logic [2:0] SEQ_ORTHO = 3'd3;
	localparam logic [2:0] SEQ_NORM_V = 3'd4;
	localparam logic [2:0] SEQ_CROSS = 3'd5;
	localparam logic [2:0] SEQ_PRESENT = 3'd6;

endpackage

// ==== source/crossProduct.sv ====
// Fixed-point cross product a x b, registered on crossStart and held until the next start
`timescale 1ns/100ps

module crossProduct import cameraPkg::*; (
	input  logic iClk,
	input  logic arstN,
	input  logic crossStart,
	input  fixT  aX, aY, aZ,
	input  fixT  bX, bY, bZ,
	output fixT  crossX, crossY, crossZ
);

	// Full-width differences before rescaling
	logic signed [36:0] diffX, diffY, diffZ;

	assign diffX = aY * bZ - aZ * bY;
	assign diffY = aZ * bX - aX * bZ;
	assign diffZ = aX * bY - aY * bX;

	always_ff @(posedge iClk or negedge arstN) begin
		if (!arstN) begin
			crossX <= '0;
			crossY <= '0;
			crossZ <= '0;
		end else if (crossStart) begin
			crossX <= fixT'(diffX >>> FRAC_BITS);
			crossY <= fixT'(diffY >>> FRAC_BITS);
			crossZ <= fixT'(diffZ >>> FRAC_BITS);
		end
	end

endmodule

// ==== source/upOrthogonalizer.sv ====
// Removes from a unit up vector its part along the unit view direction, registered on orthoStart
`timescale 1ns/100ps

module upOrthogonalizer import cameraPkg::*; (
	input  logic iClk,
	input  logic arstN,
	input  logic orthoStart,
	input  fixT  nX, nY, nZ,
	input  fixT  upX, upY, upZ,
	output fixT  orthoX, orthoY, orthoZ
);

	logic signed [37:0] dotFull;
	fixT dotFix;
	logic signed [35:0] projX, projY, projZ;

	// Dot product of up with n, back to FRAC_BITS fraction bits
	assign dotFull = upX * nX + upY * nY + upZ * nZ;
	assign dotFix = fixT'(dotFull >>> FRAC_BITS);

	// Projection of up onto n
	assign projX = nX * dotFix;
	assign projY = nY * dotFix;
	assign projZ = nZ * dotFix;

	always_ff @(posedge iClk or negedge arstN) begin
		if (!arstN) begin
			orthoX <= '0;
			orthoY <= '0;
			orthoZ <= '0;
		end else if (orthoStart) begin
			orthoX <= upX - fixT'(projX >>> FRAC_BITS);
			orthoY <= upY - fixT'(projY >>> FRAC_BITS);
			orthoZ <= upZ - fixT'(projZ >>> FRAC_BITS);
		end
	end

endmodule

// ==== source/vectorNormalizer.sv ====
// Iterative unit-vector engine, started by normStart and reporting with a one-cycle normDone
`timescale 1ns/100ps

module vectorNormalizer import cameraPkg::*; (
	input  logic iClk,
	input  logic arstN,
	input  logic normStart,
	input  fixT  normX, normY, normZ,
	output logic normDone,
	output fixT  unitX, unitY, unitZ,
	output logic zeroLength
);

	logic [1:0] state;
	logic [4:0] stepCnt;
	logic [1:0] compIdx;
	fixT vecX, vecY, vecZ;

	logic signed [35:0] sqX, sqY, sqZ;
	logic [35:0] sumSq;

	// Square root keeps two radicand bits per step
	logic [35:0] radicand;
	logic [19:0] sqrtRem;
	logic [17:0] root;
	logic [21:0] sqrtShift, sqrtTrial, sqrtRemNext;
	logic sqrtFits;

	// Restoring divider, quotient bits shift into divQ
	logic [1:0] loadIdx;
	fixT loadComp, curComp;
	logic [17:0] loadMag;
	logic [18:0] divRem, divShift, divRemNext, loadRem;
	logic [17:0] divQ, divQNext, loadQ;
	logic divFits;
	fixT quotSigned;

	function automatic fixT pickComp(input logic [1:0] idx, input fixT a, input fixT b,
		input fixT c);
		case (idx)
			2'd0: return a;
			2'd1: return b;
			default: return c;
		endcase
	endfunction

	assign sqX = vecX * vecX;
	assign sqY = vecY * vecY;
	assign sqZ = vecZ * vecZ;
	assign sumSq = $unsigned(sqX) + $unsigned(sqY) + $unsigned(sqZ);

	assign sqrtShift = {sqrtRem, radicand[35:34]};
	assign sqrtTrial = {2'b00, root, 2'b01};
	assign sqrtFits = sqrtShift >= sqrtTrial;
	assign sqrtRemNext = sqrtFits ? sqrtShift - sqrtTrial : sqrtShift;

	// Next component to load; the first load happens on the last root step
	assign loadIdx = (state == NORM_SQRT) ? 2'd0 : compIdx + 2'd1;
	assign loadComp = pickComp(loadIdx, vecX, vecY, vecZ);
	assign curComp = pickComp(compIdx, vecX, vecY, vecZ);
	assign loadMag = loadComp[FIX_WIDTH-1] ? $unsigned(-loadComp) : $unsigned(loadComp);

	// Dividend is the magnitude scaled by FRAC_BITS, upper part seeds the remainder
	assign loadRem = 19'(loadMag >> (FIX_WIDTH - FRAC_BITS));
	assign loadQ = {loadMag[FIX_WIDTH-FRAC_BITS-1:0], {FRAC_BITS{1'b0}}};

	assign divShift = {divRem[17:0], divQ[17]};
	assign divFits = divShift >= {1'b0, root};
	assign divRemNext = divFits ? divShift - {1'b0, root} : divShift;
	assign divQNext = {divQ[16:0], divFits};
	assign quotSigned = curComp[FIX_WIDTH-1] ? -fixT'(divQNext) : fixT'(divQNext);

	always_ff @(posedge iClk or negedge arstN) begin
		if (!arstN) begin
			state <= NORM_IDLE;
			stepCnt <= '0;
			compIdx <= '0;
			normDone <= 1'b0;
			zeroLength <= 1'b0;
		end else begin
			normDone <= 1'b0;
			case (state)
				NORM_IDLE: begin
					if (normStart) begin
						vecX <= normX;
						vecY <= normY;
						vecZ <= normZ;
						state <= NORM_SUM;
					end
				end
				NORM_SUM: begin
					if (sumSq == '0) begin
						// nothing to divide by, report at once
						unitX <= '0;
						unitY <= '0;
						unitZ <= '0;
						zeroLength <= 1'b1;
						normDone <= 1'b1;
						state <= NORM_IDLE;
					end else begin
						radicand <= sumSq;
						sqrtRem <= '0;
						root <= '0;
						stepCnt <= '0;
						state <= NORM_SQRT;
					end
				end
				NORM_SQRT: begin
					sqrtRem <= sqrtRemNext[19:0];
					root <= {root[16:0], sqrtFits};
					radicand <= radicand << 2;
					stepCnt <= stepCnt + 5'd1;
					if (stepCnt == SQRT_STEPS - 1) begin
						stepCnt <= '0;
						compIdx <= '0;
						divRem <= loadRem;
						divQ <= loadQ;
						state <= NORM_DIV;
					end
				end
				default: begin
					divRem <= divRemNext;
					divQ <= divQNext;
					stepCnt <= stepCnt + 5'd1;
					if (stepCnt == DIV_STEPS - 1) begin
						stepCnt <= '0;
						case (compIdx)
							2'd0: unitX <= quotSigned;
							2'd1: unitY <= quotSigned;
							default: unitZ <= quotSigned;
						endcase
						if (compIdx == 2'd2) begin
							zeroLength <= 1'b0;
							normDone <= 1'b1;
							state <= NORM_IDLE;
						end else begin
							compIdx <= compIdx + 2'd1;
							divRem <= loadRem;
							divQ <= loadQ;
						end
					end
				end
			endcase
		end
	end

endmodule

// ==== test/cameraBasisTb.sv ====
// Directed testbench for the camera basis top level, run as the simulation top from verilog.f
`timescale 1ns/100ps

module cameraBasisTb import cameraPkg::*; ();

	localparam int RANDOM_JOBS = 12;
	localparam int STALL_JOBS = 4;
	localparam int TOTAL_JOBS = 4 + RANDOM_JOBS + STALL_JOBS;
	localparam int TIMEOUT_CYCLES = TOTAL_JOBS * (3 * NORM_CYCLES + 20) * 2;

	logic iClk, arstN, inValid, inReady, outValid, outReady, degenerate;
	fixT lookFromX, lookFromY, lookFromZ;
	fixT lookToX, lookToY, lookToZ;
	fixT upX, upY, upZ;
	fixT nX, nY, nZ, vX, vY, vZ, uX, uY, uZ;

	int cycleCount;
	// Job order is lookFrom, lookTo, up; results are n, v, u
	longint job [9];
	fixT want [9];
	fixT got [9];
	logic wantDeg, gotDeg;

	cameraBasis UUT (.*);

	initial begin
		iClk = 1'b0;
		forever #5 iClk = ~iClk;
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "run stopped at the first error");
	endtask

	initial begin
		cycleCount = 0;
		forever begin
			@(posedge iClk);
			cycleCount++;
			if (UUT.props.assertFailed)
				abortRun("A bound assertion on the DUT ports failed");
			if (cycleCount >= TIMEOUT_CYCLES)
				abortRun($sformatf("Timeout after %0d cycles waiting for the DUT", cycleCount));
		end
	end

	function automatic int absDiff(input fixT a, input fixT b);
		int d;
		d = int'(a) - int'(b);
		return (d < 0) ? -d : d;
	endfunction

	task automatic checkVector(input string what, input fixT aX, input fixT aY, input fixT aZ,
		input fixT eX, input fixT eY, input fixT eZ, input int tol);
		if (absDiff(aX, eX) > tol || absDiff(aY, eY) > tol || absDiff(aZ, eZ) > tol)
			abortRun($sformatf("Fail at %0t ns: %s is (%0d,%0d,%0d), expected (%0d,%0d,%0d)",
				$time, what, aX, aY, aZ, eX, eY, eZ));
	endtask

	task automatic checkFlag(input string what, input logic actual, input logic expected);
		if (actual !== expected)
			abortRun($sformatf("Fail at %0t ns: %s is %b, expected %b",
				$time, what, actual, expected));
	endtask

	// Floor square root by bisection
	function automatic longint isqrt(input longint s);
		longint lo, hi, mid;
		lo = 0;
		hi = longint'(1) << 18;
		while (hi - lo > 1) begin
			mid = (lo + hi) / 2;
			if (mid * mid <= s)
				lo = mid;
			else
				hi = mid;
		end
		return lo;
	endfunction

	// Component times one over the floor length, truncated toward zero
	task automatic unitOf(input longint x, input longint y, input longint z,
		output longint u [3], output bit isZero);
		longint len;
		len = isqrt(x * x + y * y + z * z);
		isZero = (len == 0);
		if (isZero) begin
			u = '{0, 0, 0};
		end else begin
			u[0] = (x <<< FRAC_BITS) / len;
			u[1] = (y <<< FRAC_BITS) / len;
			u[2] = (z <<< FRAC_BITS) / len;
		end
	endtask

	task automatic modelBasis();
		longint nV [3], upV [3], oV [3], vV [3], uV [3];
		longint dot;
		bit zeroDir, zeroUp, zeroV;
		unitOf(job[3] - job[0], job[4] - job[1], job[5] - job[2], nV, zeroDir);
		unitOf(job[6], job[7], job[8], upV, zeroUp);
		dot = (upV[0] * nV[0] + upV[1] * nV[1] + upV[2] * nV[2]) >>> FRAC_BITS;
		for (int i = 0; i < 3; i++)
			oV[i] = upV[i] - ((nV[i] * dot) >>> FRAC_BITS);
		unitOf(oV[0], oV[1], oV[2], vV, zeroV);
		uV[0] = (nV[1] * vV[2] - nV[2] * vV[1]) >>> FRAC_BITS;
		uV[1] = (nV[2] * vV[0] - nV[0] * vV[2]) >>> FRAC_BITS;
		uV[2] = (nV[0] * vV[1] - nV[1] * vV[0]) >>> FRAC_BITS;
		wantDeg = zeroDir || zeroV;
		for (int i = 0; i < 3; i++) begin
			want[i] = wantDeg ? fixT'(0) : fixT'(nV[i]);
			want[3 + i] = wantDeg ? fixT'(0) : fixT'(vV[i]);
			want[6 + i] = wantDeg ? fixT'(0) : fixT'(uV[i]);
		end
	endtask

	task automatic setJob(input longint fx, fy, fz, tx, ty, tz, wx, wy, wz);
		job = '{fx, fy, fz, tx, ty, tz, wx, wy, wz};
	endtask

	task automatic setWant(input longint nx, ny, nz, vx, vy, vz, ux, uy, uz, input logic deg);
		want = '{fixT'(nx), fixT'(ny), fixT'(nz), fixT'(vx), fixT'(vy), fixT'(vz),
			fixT'(ux), fixT'(uy), fixT'(uz)};
		wantDeg = deg;
	endtask

	// Coordinates within +-2.0, |dir| >= 1.0, |up| >= 0.5, at least 30 degrees apart
	task automatic pickRandomJob();
		longint d [3], c [3];
		longint dirSq, upSq, crossSq;
		bit good;
		good = 1'b0;
		while (!good) begin
			for (int i = 0; i < 9; i++)
				job[i] = longint'($urandom_range(0, 16382)) - 8191;
			for (int i = 0; i < 3; i++)
				d[i] = job[3 + i] - job[i];
			c[0] = job[7] * d[2] - job[8] * d[1];
			c[1] = job[8] * d[0] - job[6] * d[2];
			c[2] = job[6] * d[1] - job[7] * d[0];
			dirSq = d[0] * d[0] + d[1] * d[1] + d[2] * d[2];
			upSq = job[6] * job[6] + job[7] * job[7] + job[8] * job[8];
			crossSq = c[0] * c[0] + c[1] * c[1] + c[2] * c[2];
			good = dirSq >= (1 << 24) && upSq >= (1 << 22) && 4 * crossSq >= upSq * dirSq;
		end
	endtask

	task automatic sendJob();
		@(negedge iClk);
		lookFromX = fixT'(job[0]);
		lookFromY = fixT'(job[1]);
		lookFromZ = fixT'(job[2]);
		lookToX = fixT'(job[3]);
		lookToY = fixT'(job[4]);
		lookToZ = fixT'(job[5]);
		upX = fixT'(job[6]);
		upY = fixT'(job[7]);
		upZ = fixT'(job[8]);
		inValid = 1'b1;
		while (!inReady)
			@(negedge iClk);
		@(negedge iClk);
		inValid = 1'b0;
	endtask

	task automatic captureOutputs();
		got = '{nX, nY, nZ, vX, vY, vZ, uX, uY, uZ};
		gotDeg = degenerate;
	endtask

	function automatic bit outputsHeld();
		return got[0] == nX && got[1] == nY && got[2] == nZ && got[3] == vX && got[4] == vY
			&& got[5] == vZ && got[6] == uX && got[7] == uY && got[8] == uZ
			&& gotDeg == degenerate;
	endfunction

	// With stall set, outReady stays low for a random stretch after outValid
	task automatic waitResult(input bit stall);
		int holdOff;
		bit seen, taken;
		seen = 1'b0;
		taken = 1'b0;
		holdOff = stall ? int'($urandom_range(0, 15)) : 0;
		outReady = !stall;
		while (!taken) begin
			@(negedge iClk);
			if (inReady)
				abortRun("inReady went high before the result was taken");
			if (outValid) begin
				if (!seen)
					captureOutputs();
				else if (!outputsHeld())
					abortRun($sformatf("Fail at %0t ns: result changed under back-pressure", $time));
				seen = 1'b1;
				if (holdOff > 0) begin
					outReady = 1'b0;
					holdOff--;
				end else begin
					outReady = 1'b1;
					taken = 1'b1;
				end
			end
		end
		@(negedge iClk);
		outReady = !stall;
		if (outValid)
			abortRun("outValid stayed high after the result was taken");
	endtask

	task automatic runJob(input bit stall, input int tol);
		sendJob();
		waitResult(stall);
		checkVector("n", got[0], got[1], got[2], want[0], want[1], want[2], tol);
		checkVector("v", got[3], got[4], got[5], want[3], want[4], want[5], tol);
		checkVector("u", got[6], got[7], got[8], want[6], want[7], want[8], tol);
		checkFlag("degenerate", gotDeg, wantDeg);
	endtask

	function automatic longint dotOf(input int a, input int b);
		return (longint'(got[a]) * longint'(got[b]) + longint'(got[a + 1]) * longint'(got[b + 1])
			+ longint'(got[a + 2]) * longint'(got[b + 2])) >>> FRAC_BITS;
	endfunction

	// Unit lengths and right angles of the returned basis
	task automatic checkShape();
		longint err;
		for (int i = 0; i < 9; i += 3) begin
			err = dotOf(i, i) - FIX_ONE;
			if (err > 64 || err < -64)
				abortRun($sformatf("Fail at %0t ns: squared length of vector %0d is off by %0d",
					$time, i / 3, err));
		end
		for (int i = 0; i < 6; i += 3) begin
			for (int j = i + 3; j < 9; j += 3) begin
				err = dotOf(i, j);
				if (err > 32 || err < -32)
					abortRun($sformatf("Fail at %0t ns: vectors %0d and %0d have dot product %0d",
						$time, i / 3, j / 3, err));
			end
		end
	endtask

	task automatic axisAlignedView();
		setJob(0, 0, 0, 0, 0, 5 * FIX_ONE, 0, 3 * FIX_ONE, 0);
		setWant(0, 0, FIX_ONE, 0, FIX_ONE, 0, -FIX_ONE, 0, 0, 1'b0);
		runJob(1'b0, 0);
	endtask

	task automatic tiltedUpVector();
		setJob(0, 0, 0, 0, 0, 5 * FIX_ONE, 0, 2 * FIX_ONE, FIX_ONE);
		setWant(0, 0, FIX_ONE, 0, FIX_ONE, 0, -FIX_ONE, 0, 0, 1'b0);
		runJob(1'b0, 0);
	endtask

	task automatic randomViews();
		repeat (RANDOM_JOBS) begin
			pickRandomJob();
			modelBasis();
			runJob(1'b0, 8);
			checkShape();
		end
	endtask

	task automatic degenerateViews();
		// Camera sitting on its aim point
		setJob(FIX_ONE, 2 * FIX_ONE, -FIX_ONE, FIX_ONE, 2 * FIX_ONE, -FIX_ONE, 0, FIX_ONE, 0);
		setWant(0, 0, 0, 0, 0, 0, 0, 0, 0, 1'b1);
		runJob(1'b0, 0);
		// up pointing straight back along the view
		setJob(0, 0, 0, 0, 0, 5 * FIX_ONE, 0, 0, -2 * FIX_ONE);
		runJob(1'b0, 0);
	endtask

	task automatic stalledViews();
		repeat (STALL_JOBS) begin
			pickRandomJob();
			modelBasis();
			runJob(1'b1, 8);
		end
	endtask

	initial begin
		void'($urandom(32'h54e0_b9c5));
		arstN = 1'b0;
		inValid = 1'b0;
		outReady = 1'b0;
		{lookFromX, lookFromY, lookFromZ} = '0;
		{lookToX, lookToY, lookToZ} = '0;
		{upX, upY, upZ} = '0;
		repeat (8) @(posedge iClk);
		@(negedge iClk);
		arstN = 1'b1;
		checkFlag("inReady after reset", inReady, 1'b1);
		checkFlag("outValid after reset", outValid, 1'b0);
		axisAlignedView();
		tiltedUpVector();
		randomViews();
		degenerateViews();
		stalledViews();
		if (UUT.props.assertFailed) begin
			abortRun("A bound assertion on the DUT ports failed");
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

// ==== test/cameraBasis_properties.sv ====
// Handshake and output rules of the camera basis, bound to its top level for every simulation
`timescale 1ns/100ps

module cameraBasisProperties import cameraPkg::*; (
	input logic iClk,
	input logic arstN,
	input logic inValid,
	input logic inReady,
	input logic outValid,
	input logic outReady,
	input logic degenerate,
	input fixT  nX, nY, nZ,
	input fixT  vX, vY, vZ,
	input fixT  uX, uY, uZ
);

	logic [9*FIX_WIDTH-1:0] result;
	logic jobSeen;
	// Sticky record of a failed assertion
	bit assertFailed = 1'b0;

	assign result = {nX, nY, nZ, vX, vY, vZ, uX, uY, uZ};

	// Goes high with the first accepted job
	always_ff @(posedge iClk or negedge arstN) begin
		if (!arstN)
			jobSeen <= 1'b0;
		else if (inValid && inReady)
			jobSeen <= 1'b1;
	end

	// Idle and presenting are separate sequencer states
	assert property (@(posedge iClk) disable iff (!arstN) !(inReady && outValid))
		else begin
			$error("inReady and outValid are high together");
			assertFailed = 1'b1;
		end

	assert property (@(posedge iClk) disable iff (!arstN)
		outValid && !outReady |=> outValid && $stable(result) && $stable(degenerate))
		else begin
			$error("result changed while outReady was low");
			assertFailed = 1'b1;
		end

	assert property (@(posedge iClk) disable iff (!arstN) degenerate |-> result == '0)
		else begin
			$error("degenerate result has a nonzero output");
			assertFailed = 1'b1;
		end

	assert property (@(posedge iClk) disable iff (!arstN) !jobSeen |-> !outValid && !degenerate)
		else begin
			$error("outValid or degenerate high after reset before any job was accepted");
			assertFailed = 1'b1;
		end

endmodule

bind cameraBasis cameraBasisProperties props (.*);

// ==== verilog.f ====
source/cameraPkg.sv
source/vectorNormalizer.sv
source/upOrthogonalizer.sv
source/crossProduct.sv
source/basisSequencer.sv
source/cameraBasis.sv
test/cameraBasis_properties.sv
test/cameraBasisTb.sv
